//--- vlog.f
cpu_pkg.sv
cpu_alu.sv
cpu_core.sv
bus_frame_handler.sv
cpu_pin_top.sv
tb_pin_memory.sv
tb_cpu_pin_top.sv

//--- Bender.yml
package:
  name: cpu_pin_top

sources:
  - cpu_pkg.sv
  - cpu_alu.sv
  - cpu_core.sv
  - bus_frame_handler.sv
  - cpu_pin_top.sv
  - target: simulation
    files:
      - tb_pin_memory.sv
      - tb_cpu_pin_top.sv

//--- tb_cpu_pin_top.sv
`timescale 1ns/100ps

module tb_cpu_pin_top;

  import cpu_pkg::*;

  localparam int          MEM_WORDS      = 64;
  localparam int          DATA_BASE      = 32;    // Data region above the longest program
  localparam int          DATA_WORDS     = 16;
  localparam int          NUM_PROGRAMS   = 5;
  localparam int          RESET_CYCLES   = 16;
  // Programs x instructions x frames x cycles per frame x margin
  localparam int          TIMEOUT_CYCLES = NUM_PROGRAMS * 24 * 2 * 11 * 2;
  localparam logic [31:0] SEED           = 32'h5761_ba69;

  logic      clk;
  logic      reset;
  pin_byte_t addr_pins;
  pin_byte_t data_pins_out;
  pin_byte_t data_pins_in;
  pin_byte_t data_oe;
  logic      bus_strobe;
  logic      halted;

  word_t     image   [0:MEM_WORDS-1];    // Program and data of the current run
  word_t     exp_mem [0:MEM_WORDS-1];
  bus_req_t  exp_frames[$];
  int        cycle_count = 0;
  int        strobe_age  = -1;

  cpu_pin_top cpu_pin_top_inst (
    .clk           (clk),
    .reset         (reset),
    .addr_pins     (addr_pins),
    .data_pins_out (data_pins_out),
    .data_pins_in  (data_pins_in),
    .data_oe       (data_oe),
    .bus_strobe    (bus_strobe),
    .halted        (halted)
  );

  tb_pin_memory #(.MEM_WORDS(MEM_WORDS)) mem_model (
    .clk           (clk),
    .addr_pins     (addr_pins),
    .data_pins_out (data_pins_out),
    .data_oe       (data_oe),
    .bus_strobe    (bus_strobe),
    .data_pins_in  (data_pins_in)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_equal(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, halted never came", cycle_count);
      $display(">>> FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  // req_done belongs in the ninth pin cycle, counted from the strobe
  always @(negedge clk) begin
    if (bus_strobe === 1'b1) begin
      strobe_age = 0;
    end else if (strobe_age >= 0) begin
      strobe_age++;
    end
    if (!reset) begin
      check_equal("req_done frame timing", (strobe_age == 8), cpu_pin_top_inst.req_done);
    end
  end

  function automatic bus_req_t make_req(input word_t addr, input word_t wdata, input logic write);
    bus_req_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.write = write;
    return req;
  endfunction

  task automatic build_program(input int prog);
    opcode_t body_ops [0:6] = '{OP_LDI, OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_AND, OP_XOR};
    opcode_t op;
    int      len;
    int      jz_pos;
    int      i;
    for (i = 0; i < MEM_WORDS; i++) begin
      image[i] = {OP_HALT, 28'(i)};             // Stray fetches stop the core
    end
    for (i = 0; i < DATA_WORDS; i++) begin
      image[DATA_BASE + i] = $urandom();
    end
    len    = $urandom_range(24, 8);
    jz_pos = $urandom_range(len - 3, 1);
    for (i = 0; i < len - 1; i++) begin
      op = body_ops[$urandom_range(6, 0)];
      if (op == OP_LDI) begin
        image[i] = {op, 28'($urandom())};
      end else begin
        image[i] = {op, 28'(DATA_BASE + $urandom_range(DATA_WORDS - 1, 0))};
      end
    end
    // Zero before the branch in every other program, so both outcomes occur
    image[jz_pos - 1] = {OP_LDI, (prog % 2 == 0) ? 28'd0 : 28'($urandom() | 32'd1)};
    image[jz_pos]     = {OP_JZ, 28'($urandom_range(len - 1, jz_pos + 2))};  // Skips at least one
    image[len - 1]    = {OP_HALT, 28'd0};
  endtask

  task automatic run_model();
    word_t   pc;
    word_t   acc;
    word_t   instr;
    word_t   opnd;
    word_t   data;
    opcode_t op;
    int      steps;
    logic    done;
    exp_frames.delete();
    for (steps = 0; steps < MEM_WORDS; steps++) begin
      exp_mem[steps] = image[steps];
    end
    pc    = RESET_PC;
    acc   = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4 * MEM_WORDS) begin
      exp_frames.push_back(make_req(pc, '0, 1'b0));   // Instruction fetch
      instr = exp_mem[pc];
      op    = opcode_t'(instr[31:28]);
      opnd  = {4'h0, instr[27:0]};
      pc    = pc + 1;
      steps++;
      if (op inside {OP_LOAD, OP_ADD, OP_SUB, OP_AND, OP_XOR}) begin
        exp_frames.push_back(make_req(opnd, '0, 1'b0));
        data = exp_mem[opnd];
      end
      case (op)
        OP_LDI:  acc = opnd;
        OP_LOAD: acc = data;
        OP_ADD:  acc = acc + data;
        OP_SUB:  acc = acc - data;
        OP_AND:  acc = acc & data;
        OP_XOR:  acc = acc ^ data;
        OP_STORE: begin
          exp_frames.push_back(make_req(opnd, acc, 1'b1));
          exp_mem[opnd] = acc;
        end
        OP_JMP:  pc = opnd;
        OP_JZ:   pc = (acc == '0) ? opnd : pc;
        OP_HALT: done = 1'b1;
        default: ;
      endcase
    end
  endtask

  task automatic run_program(input int prog);
    bus_req_t got;
    int       halt_strobes;
    int       n;
    int       i;
    build_program(prog);
    run_model();
    @(posedge clk);
    #1 reset = 1'b1;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_model.mem[i] = image[i];
    end
    mem_model.frames.delete();
    mem_model.frame_errors = 0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_equal("bus_strobe in reset", 0, bus_strobe);
    check_equal("data_oe in reset", 0, data_oe);
    check_equal("addr_pins in reset", 0, addr_pins);
    check_equal("data_pins_out in reset", 0, data_pins_out);
    check_equal("halted in reset", 0, halted);
    @(posedge clk);
    #1 reset = 1'b0;
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
    halt_strobes = mem_model.strobe_count;
    repeat (20) @(negedge clk);                  // Bus must stay quiet once halted
    check_equal($sformatf("prog %0d strobes after halt", prog), halt_strobes,
                mem_model.strobe_count);
    n = (mem_model.frames.size() < exp_frames.size()) ? mem_model.frames.size()
                                                       : exp_frames.size();
    for (i = 0; i < n; i++) begin
      got = mem_model.frames[i];
      check_equal($sformatf("prog %0d frame %0d address", prog, i), exp_frames[i].addr, got.addr);
      check_equal($sformatf("prog %0d frame %0d direction", prog, i), exp_frames[i].write,
                  got.write);
      if (exp_frames[i].write) begin
        check_equal($sformatf("prog %0d frame %0d write data", prog, i), exp_frames[i].wdata,
                    got.wdata);
      end
    end
    check_equal($sformatf("prog %0d frame count", prog), exp_frames.size(),
                mem_model.frames.size());
    check_equal($sformatf("prog %0d pin format errors", prog), 0, mem_model.frame_errors);
    for (i = 0; i < MEM_WORDS; i++) begin
      check_equal($sformatf("prog %0d memory word %0d", prog, i), exp_mem[i], mem_model.mem[i]);
    end
  endtask

  initial begin
    int prog;
    reset = 1'b1;
    void'($urandom(SEED));
    for (prog = 0; prog < NUM_PROGRAMS; prog++) begin
      run_program(prog);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- tb_pin_memory.sv
`timescale 1ns/100ps

module tb_pin_memory #(
  parameter int MEM_WORDS = 64
) (
  input  logic               clk,
  input  cpu_pkg::pin_byte_t addr_pins,
  input  cpu_pkg::pin_byte_t data_pins_out,
  input  cpu_pkg::pin_byte_t data_oe,
  input  logic               bus_strobe,
  output cpu_pkg::pin_byte_t data_pins_in
);

  import cpu_pkg::*;

  word_t    mem [0:MEM_WORDS-1];
  bus_req_t frames[$];           // Decoded frames in bus order
  int       frame_errors = 0;    // Pin format faults seen inside frames
  int       strobe_count = 0;

  initial begin
    data_pins_in = '0;
  end

  // Entered at the falling edge of the first address cycle
  task automatic decode_frame();
    bus_req_t  req;
    word_t     rword;
    pin_byte_t oe_seen [1:5];
    logic      in_range;
    int        p;
    req = '0;
    strobe_count++;
    for (p = 1; p <= 4; p++) begin
      if (p > 1) begin
        @(negedge clk);
      end
      req.addr[8*(p-1) +: 8]  = addr_pins;      // Low byte first
      req.wdata[8*(p-1) +: 8] = data_pins_out;
      oe_seen[p]              = data_oe;
    end
    in_range = (req.addr < MEM_WORDS);
    rword    = in_range ? mem[req.addr] : '0;
    @(posedge clk);
    #1 data_pins_in = rword[7:0];               // Taken at the end of the direction cycle
    @(negedge clk);
    req.write  = addr_pins[0];                  // Direction slot
    oe_seen[5] = data_oe;
    if (!in_range || addr_pins[7:1] !== 7'd0) begin
      frame_errors++;
    end
    for (p = 1; p <= 5; p++) begin
      if (oe_seen[p] !== (req.write ? 8'hff : 8'h00)) begin
        frame_errors++;
      end
    end
    if (req.write && in_range) begin
      mem[req.addr] = req.wdata;
    end
    frames.push_back(req);
    // Remaining read bytes, then the pins must stay idle to the end of the frame
    for (p = 1; p <= 4; p++) begin
      @(posedge clk);
      #1 data_pins_in = (p < 4) ? rword[8*p +: 8] : 8'h00;
      @(negedge clk);
      if (data_oe !== 8'h00 || addr_pins !== 8'h00 || bus_strobe !== 1'b0) begin
        frame_errors++;
      end
    end
  endtask

  always begin
    @(negedge clk);
    if (bus_strobe === 1'b1) begin
      decode_frame();
    end
  end

endmodule

//--- cpu_pin_top.sv
`timescale 1ns/100ps

module cpu_pin_top (
  input  logic               clk,
  input  logic               reset,
  output cpu_pkg::pin_byte_t addr_pins,
  output cpu_pkg::pin_byte_t data_pins_out,
  input  cpu_pkg::pin_byte_t data_pins_in,
  output cpu_pkg::pin_byte_t data_oe,
  output logic               bus_strobe,
  output logic               halted
);

  import cpu_pkg::*;

  bus_req_t bus_req;
  logic     req_valid;
  word_t    rdata;
  logic     req_done;

  cpu_core cpu_core_inst (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .req_valid (req_valid),
    .rdata     (rdata),
    .req_done  (req_done),
    .halted    (halted)
  );

  // Serializes each core request over the 8-bit pins
  bus_frame_handler bus_frame_handler_inst (
    .clk           (clk),
    .reset         (reset),
    .bus_req       (bus_req),
    .req_valid     (req_valid),
    .rdata         (rdata),
    .req_done      (req_done),
    .addr_pins     (addr_pins),
    .data_pins_out (data_pins_out),
    .data_oe       (data_oe),
    .data_pins_in  (data_pins_in),
    .bus_strobe    (bus_strobe)
  );

endmodule

//--- bus_frame_handler.sv
`timescale 1ns/100ps

module bus_frame_handler (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::bus_req_t  bus_req,
  input  logic               req_valid,
  output cpu_pkg::word_t     rdata,
  output logic               req_done,
  output cpu_pkg::pin_byte_t addr_pins,
  output cpu_pkg::pin_byte_t data_pins_out,
  output cpu_pkg::pin_byte_t data_oe,
  input  cpu_pkg::pin_byte_t data_pins_in,
  output logic               bus_strobe
);

  import cpu_pkg::*;

  frame_slot_t slot;
  bus_req_t    req_q;       // Request held for the whole frame
  logic        accept;

  // req_done sits in slot 0 while req_valid is still high, so keep it out
  assign accept = (slot == '0) && req_valid && !req_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot     <= '0;
      req_done <= 1'b0;
    end else begin
      req_done <= (slot == SLOT_LAST);  // Last read byte lands at this edge
      if (slot == '0) begin
        if (accept) begin
          slot <= 4'd1;
        end
      end else if (slot == SLOT_LAST) begin
        slot <= '0;
      end else begin
        slot <= slot + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= bus_req;
    end
  end

  // Pin outputs are registered and trail their slot by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_pins     <= '0;
      data_pins_out <= '0;
      data_oe       <= '0;
      bus_strobe    <= 1'b0;
    end else begin
      bus_strobe <= (slot == 4'd1);
      data_oe    <= (req_q.write && slot >= 4'd1 && slot <= SLOT_DIR) ? 8'hff : 8'h00;
      case (slot)
        4'd1: begin
          addr_pins     <= req_q.addr[7:0];     // Low byte first
          data_pins_out <= req_q.wdata[7:0];
        end
        4'd2: begin
          addr_pins     <= req_q.addr[15:8];
          data_pins_out <= req_q.wdata[15:8];
        end
        4'd3: begin
          addr_pins     <= req_q.addr[23:16];
          data_pins_out <= req_q.wdata[23:16];
        end
        4'd4: begin
          addr_pins     <= req_q.addr[31:24];
          data_pins_out <= req_q.wdata[31:24];
        end
        SLOT_DIR: begin
          addr_pins     <= {7'b0000000, req_q.write};
          data_pins_out <= '0;
        end
        default: begin
          addr_pins     <= '0;                  // Pins idle outside the output slots
          data_pins_out <= '0;
        end
      endcase
    end
  end

  // Read bytes are sampled at the edge that ends each slot
  always_ff @(posedge clk) begin
    case (slot)
      4'd6:      rdata[7:0]   <= data_pins_in;
      4'd7:      rdata[15:8]  <= data_pins_in;
      4'd8:      rdata[23:16] <= data_pins_in;
      SLOT_LAST: rdata[31:24] <= data_pins_in;
      default:   rdata        <= rdata;
    endcase
  end

  // Every accepted request finishes a fixed frame later
  a_frame_length: assert property (
    @(posedge clk) disable iff (reset)
    accept |-> ##FRAME_CYCLES req_done
  ) else $error("request not completed after one frame");

  // req_done only at the end of an accepted frame
  a_done_origin: assert property (
    @(posedge clk) disable iff (reset)
    req_done |-> $past(accept, FRAME_CYCLES)
  ) else $error("req_done without a matching frame");

endmodule

//--- cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
  input  logic              clk,
  input  logic              reset,
  output cpu_pkg::bus_req_t bus_req,
  output logic              req_valid,
  input  cpu_pkg::word_t    rdata,
  input  logic              req_done,
  output logic              halted
);

  import cpu_pkg::*;

  core_state_t state;
  word_t       pc;          // Word address of the next instruction
  word_t       acc;
  word_t       ir;

  opcode_t     opcode;
  operand_t    imm;
  word_t       imm_ext;
  word_t       alu_operand;
  word_t       alu_result;
  logic        alu_zero;

  assign opcode  = opcode_t'(ir[31:28]);
  assign imm     = ir[27:0];
  assign imm_ext = {4'b0000, imm};

  // Memory data feeds the ALU only once the data frame has returned
  assign alu_operand = (state == MEM_WAIT) ? rdata : imm_ext;

  cpu_alu alu_inst (
    .op      (opcode),
    .acc     (acc),
    .operand (alu_operand),
    .result  (alu_result),
    .zero    (alu_zero)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= FETCH;
      pc        <= RESET_PC;
      acc       <= '0;
      req_valid <= 1'b0;
      halted    <= 1'b0;
    end else begin
      unique case (state)
        FETCH: begin
          req_valid <= 1'b1;          // Request and its payload rise together
          state     <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (req_done) begin
            req_valid <= 1'b0;
            state     <= EXEC;
          end
        end
        EXEC: begin
          unique case (opcode)
            OP_LDI: begin
              acc   <= alu_result;
              pc    <= pc + 32'd1;
              state <= FETCH;
            end
            OP_JMP: begin
              pc    <= imm_ext;
              state <= FETCH;
            end
            OP_JZ: begin
              pc    <= alu_zero ? imm_ext : pc + 32'd1;
              state <= FETCH;
            end
            OP_HALT: begin
              halted <= 1'b1;
              state  <= HALTED;
            end
            OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
              req_valid <= 1'b1;      // Second frame for the data access
              state     <= MEM_WAIT;
            end
            default: begin
              // Unused encodings behave as a no-op
              pc    <= pc + 32'd1;
              state <= FETCH;
            end
          endcase
        end
        MEM_WAIT: begin
          if (req_done) begin
            req_valid <= 1'b0;
            if (opcode != OP_STORE) begin
              acc <= alu_result;
            end
            pc    <= pc + 32'd1;
            state <= FETCH;
          end
        end
        HALTED: begin
          halted <= 1'b1;             // Only reset leaves this state
        end
        default: begin
          state <= HALTED;
        end
      endcase
    end
  end

  // Instruction register and the payload of the next request
  always_ff @(posedge clk) begin
    if (state == FETCH_WAIT && req_done) begin
      ir <= rdata;
    end
    if (state == FETCH) begin
      bus_req.addr  <= pc;
      bus_req.wdata <= '0;
      bus_req.write <= 1'b0;
    end else if (state == EXEC) begin
      bus_req.addr  <= imm_ext;
      bus_req.wdata <= acc;           // Only meaningful for OP_STORE
      bus_req.write <= (opcode == OP_STORE);
    end
  end

  // The handler latches the request only in slot 0, so it must hold until done
  a_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    (req_valid && !req_done) |=> (req_valid && $stable(bus_req))
  ) else $error("bus_req changed while a request was pending");

  // No bus traffic is started once the core has halted
  a_halt_quiet: assert property (
    @(posedge clk) disable iff (reset)
    halted |=> !req_valid
  ) else $error("request issued after halt");

endmodule

//--- cpu_alu.sv
`timescale 1ns/100ps

module cpu_alu (
  input  cpu_pkg::opcode_t op,
  input  cpu_pkg::word_t   acc,
  input  cpu_pkg::word_t   operand,
  output cpu_pkg::word_t   result,
  output logic             zero
);

  import cpu_pkg::*;

  always_comb begin
    unique case (op)
      OP_LDI: begin
        result = operand;         // Immediate, already zero-extended
      end
      OP_LOAD: begin
        result = operand;         // Word read from memory
      end
      OP_ADD: begin
        result = acc + operand;   // Wraps at 32 bits
      end
      OP_SUB: begin
        result = acc - operand;
      end
      OP_AND: begin
        result = acc & operand;
      end
      OP_XOR: begin
        result = acc ^ operand;
      end
      default: begin
        // Store, jumps and halt leave the accumulator alone
        result = acc;
      end
    endcase
  end

  // With a pass-through opcode this is simply the accumulator test used by OP_JZ
  assign zero = (result == '0);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  // Data words and addresses share one width
  typedef logic [31:0] word_t;
  typedef logic [7:0]  pin_byte_t;
  typedef logic [27:0] operand_t;   // Address or immediate, zero-extended
  typedef logic [3:0]  frame_slot_t;

  // Instruction word layout is opcode in [31:28], operand in [27:0]
  typedef enum logic [3:0] {
    OP_LDI   = 4'h0,
    OP_LOAD  = 4'h1,
    OP_STORE = 4'h2,
    OP_ADD   = 4'h3,
    OP_SUB   = 4'h4,
    OP_AND   = 4'h5,
    OP_XOR   = 4'h6,
    OP_JMP   = 4'h7,
    OP_JZ    = 4'h8,
    OP_HALT  = 4'h9
  } opcode_t;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_WAIT,
    EXEC,
    MEM_WAIT,
    HALTED
  } core_state_t;

  // One memory request from the core to the frame handler
  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } bus_req_t;

  // Slots 1-4 carry address and write data, slot 5 the direction, 6-9 read data
  localparam frame_slot_t SLOT_DIR     = 4'd5;
  localparam frame_slot_t SLOT_LAST    = 4'd9;
  localparam int          FRAME_CYCLES = 10;

  localparam word_t RESET_PC = 32'h0000_0000;

endpackage
